// File: rtl/ac97_pkg.sv
//////////////////////////////////////////////////
// Types and widths shared by the AC'97 register and DMA blocks.
// Slots are 20 bits and PCM samples are 16 bits, left aligned in the slot.
// Memory addresses are 30-bit word addresses.
//////////////////////////////////////////////////

package ac97_pkg;

	localparam int slot_w = 20;   // width of one AC-link slot.
	localparam int sample_w = 16; // PCM samples sit in the top bits of a slot.

	// one CSR bus cycle.
	typedef struct packed {
		logic [13:0] addr;
		logic        we;
		logic [31:0] data;
	} csr_req_t;

	// register offsets inside the CSR page.
	typedef enum logic [3:0] {
		csr_ctrl      = 4'd0,
		csr_cr_addr   = 4'd1,
		csr_cr_wdata  = 4'd2,
		csr_cr_reply  = 4'd3,  // read only.
		csr_rd_en     = 4'd4,
		csr_rd_addr   = 4'd5,
		csr_rd_remain = 4'd6,
		csr_wr_en     = 4'd8,
		csr_wr_addr   = 4'd9,
		csr_wr_remain = 4'd10
	} csr_reg_e;

	// outgoing frame content.
	typedef struct packed {
		logic              addr_valid;
		logic [slot_w-1:0] addr;
		logic              data_valid;
		logic [slot_w-1:0] data;
		logic              left_valid;
		logic [slot_w-1:0] left;
		logic              right_valid;
		logic [slot_w-1:0] right;
	} link_down_t;

	// incoming frame content, qualified by the frame valid bit.
	typedef struct packed {
		logic              frame_valid;
		logic              addr_valid;
		logic [slot_w-1:0] addr;
		logic              data_valid;
		logic [slot_w-1:0] data;
		logic              left_valid;
		logic [slot_w-1:0] left;
		logic              right_valid;
		logic [slot_w-1:0] right;
	} link_up_t;

	// channel state from the register file to a DMA block.
	typedef struct packed {
		logic        active;
		logic [29:0] addr;
	} dma_ctl_t;

	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [29:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	// all four are single-cycle pulses.
	typedef struct packed {
		logic crrequest;
		logic crreply;
		logic dmar;
		logic dmaw;
	} irq_t;

	typedef enum logic {
		grant_reader = 1'b0,
		grant_writer = 1'b1
	} grant_e;

	typedef enum logic [1:0] {
		empty    = 2'd0,
		fetching = 2'd1,
		full     = 2'd2
	} fill_e;

endpackage

// File: rtl/ac97_ctlif.sv
//////////////////////////////////////////////////
// CSR register file of the AC'97 controller.
// Read data is registered, so it shows one cycle after the address.
// Addresses and counts are in bytes on the bus and in words inside.
// Remaining counts are 16 bits wide (bus bits 17 to 2).
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ac97_ctlif import ac97_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  csr_req_t    csr,
	output logic [31:0] csr_do,

	output irq_t        irq,

	input  logic        down_en,
	input  logic        down_next_frame,
	output link_down_t  down_cmd,

	input  logic        up_en,
	input  logic        up_next_frame,
	input  link_up_t    up,

	output dma_ctl_t    dmar,
	input  logic        dmar_next,
	output dma_ctl_t    dmaw,
	input  logic        dmaw_next
);

	localparam int rem_w = 16;

	logic              request_en;
	logic              request_write;
	logic [6:0]        request_addr;
	logic [15:0]       request_data;
	logic [15:0]       reply_data;

	logic              down_addr_valid;
	logic [slot_w-1:0] down_addr;
	logic              down_data_valid;
	logic [slot_w-1:0] down_data;

	logic              dmar_en;
	logic [29:0]       dmar_addr;
	logic [rem_w-1:0]  dmar_remaining;
	logic              dmaw_en;
	logic [29:0]       dmaw_addr;
	logic [rem_w-1:0]  dmaw_remaining;

	logic              dmar_finished;
	logic              dmar_finished_r;
	logic              dmaw_finished;
	logic              dmaw_finished_r;

	logic              csr_selected;
	csr_reg_e          offset;

	assign csr_selected = (csr.addr[13:10] == csr_addr);
	assign offset = csr_reg_e'(csr.addr[3:0]);

	//////////////////////////////////////////////////
	// channel status.
	//////////////////////////////////////////////////

	assign dmar_finished = (dmar_remaining == '0);
	assign dmaw_finished = (dmaw_remaining == '0);

	assign dmar = '{active: dmar_en & ~dmar_finished, addr: dmar_addr};
	assign dmaw = '{active: dmaw_en & ~dmaw_finished, addr: dmaw_addr};

	// reset leaves both counts at zero, so the copies start set and no edge is seen.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			dmar_finished_r <= 1'b1;
			dmaw_finished_r <= 1'b1;
		end else begin
			dmar_finished_r <= dmar_finished;
			dmaw_finished_r <= dmaw_finished;
		end
	end

	assign down_cmd = '{
		addr_valid:  down_addr_valid,
		addr:        down_addr,
		data_valid:  down_data_valid,
		data:        down_data,
		left_valid:  1'b0,
		left:        '0,
		right_valid: 1'b0,
		right:       '0
	};

	// address and data slots only matter while their valid bits are set.
	always_ff @(posedge sys_clk) begin
		if (down_en & down_next_frame) begin
			down_addr <= {~request_write, request_addr, 12'd0}; // bit 19 marks a read.
			down_data <= {request_data, {(slot_w-sample_w){1'b0}}};
		end
	end

	//////////////////////////////////////////////////
	// codec request, reply and DMA registers.
	//////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= 32'd0;
			irq <= '0;
			request_en <= 1'b0;
			request_write <= 1'b0;
			request_addr <= 7'd0;
			request_data <= 16'd0;
			reply_data <= 16'd0;
			down_addr_valid <= 1'b0;
			down_data_valid <= 1'b0;
			dmar_en <= 1'b0;
			dmar_addr <= 30'd0;
			dmar_remaining <= '0;
			dmaw_en <= 1'b0;
			dmaw_addr <= 30'd0;
			dmaw_remaining <= '0;
		end else begin
			irq <= '0;

			// the pending request goes out on the next frame and then clears.
			if (down_en & down_next_frame) begin
				down_addr_valid <= request_en;
				down_data_valid <= request_en & request_write;
				request_en <= 1'b0;
				irq.crrequest <= request_en;
			end

			if (up_en & up_next_frame & up.frame_valid & up.addr_valid & up.data_valid) begin
				reply_data <= up.data[slot_w-1:slot_w-sample_w];
				irq.crreply <= 1'b1;
			end

			if (dmar_next) begin
				dmar_addr <= dmar_addr + 30'd1;
				dmar_remaining <= dmar_remaining - rem_w'(1);
			end
			if (dmaw_next) begin
				dmaw_addr <= dmaw_addr + 30'd1;
				dmaw_remaining <= dmaw_remaining - rem_w'(1);
			end

			irq.dmar <= dmar_finished & ~dmar_finished_r;
			irq.dmaw <= dmaw_finished & ~dmaw_finished_r;

			// a CSR write overrides a DMA advance in the same cycle.
			if (csr_selected & csr.we) begin
				case (offset)
					csr_ctrl: begin
						request_en <= csr.data[0];
						request_write <= csr.data[1];
					end
					csr_cr_addr:   request_addr <= csr.data[6:0];
					csr_cr_wdata:  request_data <= csr.data[15:0];
					csr_rd_en:     dmar_en <= csr.data[0];
					csr_rd_addr:   dmar_addr <= csr.data[31:2];
					csr_rd_remain: dmar_remaining <= csr.data[rem_w+1:2];
					csr_wr_en:     dmaw_en <= csr.data[0];
					csr_wr_addr:   dmaw_addr <= csr.data[31:2];
					csr_wr_remain: dmaw_remaining <= csr.data[rem_w+1:2];
					default: ; // the reply register ignores writes.
				endcase
			end

			csr_do <= 32'd0;
			if (csr_selected) begin
				case (offset)
					csr_ctrl:      csr_do <= {30'd0, request_write, request_en};
					csr_cr_addr:   csr_do <= {25'd0, request_addr};
					csr_cr_wdata:  csr_do <= {16'd0, request_data};
					csr_cr_reply:  csr_do <= {16'd0, reply_data};
					csr_rd_en:     csr_do <= {31'd0, dmar_en};
					csr_rd_addr:   csr_do <= {dmar_addr, 2'b00};
					csr_rd_remain: csr_do <= {{(30-rem_w){1'b0}}, dmar_remaining, 2'b00};
					csr_wr_en:     csr_do <= {31'd0, dmaw_en};
					csr_wr_addr:   csr_do <= {dmaw_addr, 2'b00};
					csr_wr_remain: csr_do <= {{(30-rem_w){1'b0}}, dmaw_remaining, 2'b00};
					default:       csr_do <= 32'd0;
				endcase
			end
		end
	end

endmodule

// File: rtl/ac97_dma_reader.sv
//////////////////////////////////////////////////
// Playback DMA: one word buffer between memory and the downstream frames.
// Memory read data must be valid one cycle after the grant.
// A frame that finds the buffer empty sends invalid PCM slots.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ac97_dma_reader import ac97_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  dma_ctl_t    ctl,
	output mem_req_t    req,
	input  logic        grant,
	input  logic [31:0] mem_rdata,

	input  logic        down_en,
	input  logic        down_next_frame,
	output link_down_t  pcm
);

	fill_e             state;
	logic [31:0]       word_buf;
	logic              frame;
	logic              pcm_valid;
	logic [slot_w-1:0] left_slot;
	logic [slot_w-1:0] right_slot;

	assign frame = down_en & down_next_frame;

	// the request holds until the arbiter grants it.
	assign req = '{rd: ctl.active & (state == empty), wr: 1'b0, addr: ctl.addr, wdata: '0};

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= empty;
		end else begin
			case (state)
				empty:    if (grant) state <= fetching;
				fetching: state <= full;     // data is on mem_rdata now.
				full:     if (frame) state <= empty;
				default:  state <= empty;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == fetching)
			word_buf <= mem_rdata;
	end

	// Left sample is the upper half of the word.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pcm_valid <= 1'b0;
		end else if (frame) begin
			pcm_valid <= (state == full); // anything else is an underrun.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (frame) begin
			left_slot <= {word_buf[31:16], {(slot_w-sample_w){1'b0}}};
			right_slot <= {word_buf[15:0], {(slot_w-sample_w){1'b0}}};
		end
	end

	assign pcm = '{
		addr_valid:  1'b0,
		addr:        '0,
		data_valid:  1'b0,
		data:        '0,
		left_valid:  pcm_valid,
		left:        left_slot,
		right_valid: pcm_valid,
		right:       right_slot
	};

endmodule

// File: rtl/ac97_dma_writer.sv
//////////////////////////////////////////////////
// Capture DMA: packs one stereo frame into one memory word.
// Only one write can be pending; frames that arrive meanwhile are lost.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ac97_dma_writer import ac97_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst,

	input  dma_ctl_t ctl,
	output mem_req_t req,
	input  logic     grant,

	input  logic     up_en,
	input  logic     up_next_frame,
	input  link_up_t up
);

	logic        pending;
	logic [31:0] word;
	logic        take;

	// a frame counts only with both PCM slots valid and room for the word.
	assign take = up_en & up_next_frame & up.frame_valid & up.left_valid &
		up.right_valid & ctl.active & ~pending;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pending <= 1'b0;
		end else if (take) begin
			pending <= 1'b1;
		end else if (grant) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take)
			word <= {up.left[slot_w-1:slot_w-sample_w], up.right[slot_w-1:slot_w-sample_w]};
	end

	// The address comes from the channel and only moves on a grant.
	assign req = '{rd: 1'b0, wr: pending, addr: ctl.addr, wdata: word};

endmodule

// File: rtl/ac97_mem_arbiter.sv
//////////////////////////////////////////////////
// Single memory port shared by playback and capture DMA.
// Strobes are registered; the grant pulses with the strobe.
// A write request beats a read request in the same cycle.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ac97_mem_arbiter import ac97_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst,

	input  mem_req_t rd_req,
	output logic     rd_grant,
	input  mem_req_t wr_req,
	output logic     wr_grant,

	output mem_req_t mem
);

	grant_e      sel;
	logic        strobe;
	logic [29:0] addr_q;
	logic [31:0] wdata_q;
	logic        rd_ok;
	logic        wr_ok;

	// A requester still shows its request while its grant is out, so skip it then.
	assign wr_ok = wr_req.wr & ~wr_grant;
	assign rd_ok = rd_req.rd & ~rd_grant;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			strobe <= 1'b0;
			sel <= grant_reader;
		end else begin
			strobe <= wr_ok | rd_ok;
			if (wr_ok)
				sel <= grant_writer;
			else if (rd_ok)
				sel <= grant_reader;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_ok) begin
			addr_q <= wr_req.addr;
			wdata_q <= wr_req.wdata;
		end else if (rd_ok) begin
			addr_q <= rd_req.addr;
			wdata_q <= rd_req.wdata;
		end
	end

	assign mem = '{
		rd:    strobe & (sel == grant_reader),
		wr:    strobe & (sel == grant_writer),
		addr:  addr_q,
		wdata: wdata_q
	};

	assign rd_grant = mem.rd;
	assign wr_grant = mem.wr;

endmodule

// File: rtl/ac97_subsys.sv
//////////////////////////////////////////////////
// AC'97 controller, register and DMA side.
// The AC-link transceiver is external and supplies the frame strobes.
// Memory must answer reads one cycle after the strobe.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ac97_subsys import ac97_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  csr_req_t    csr,
	output logic [31:0] csr_do,
	output irq_t        irq,

	input  logic        down_en,
	input  logic        down_next_frame,
	output link_down_t  down,

	input  logic        up_en,
	input  logic        up_next_frame,
	input  link_up_t    up,

	output mem_req_t    mem,
	input  logic [31:0] mem_rdata
);

	link_down_t down_cmd;
	link_down_t down_pcm;
	dma_ctl_t   dmar;
	dma_ctl_t   dmaw;
	mem_req_t   rd_req;
	mem_req_t   wr_req;
	logic       rd_grant;
	logic       wr_grant;

	ac97_ctlif #(
		.csr_addr(csr_addr)
	) ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr(csr),
		.csr_do(csr_do),
		.irq(irq),
		.down_en(down_en),
		.down_next_frame(down_next_frame),
		.down_cmd(down_cmd),
		.up_en(up_en),
		.up_next_frame(up_next_frame),
		.up(up),
		.dmar(dmar),
		.dmar_next(rd_grant),   // each grant moves the channel on by one word.
		.dmaw(dmaw),
		.dmaw_next(wr_grant)
	);

	ac97_dma_reader reader (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.ctl(dmar),
		.req(rd_req),
		.grant(rd_grant),
		.mem_rdata(mem_rdata),
		.down_en(down_en),
		.down_next_frame(down_next_frame),
		.pcm(down_pcm)
	);

	ac97_dma_writer writer (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.ctl(dmaw),
		.req(wr_req),
		.grant(wr_grant),
		.up_en(up_en),
		.up_next_frame(up_next_frame),
		.up(up)
	);

	ac97_mem_arbiter arbiter (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.rd_req(rd_req),
		.rd_grant(rd_grant),
		.wr_req(wr_req),
		.wr_grant(wr_grant),
		.mem(mem)
	);

	// Command slots come from the register file, PCM slots from the reader.
	assign down = '{
		addr_valid:  down_cmd.addr_valid,
		addr:        down_cmd.addr,
		data_valid:  down_cmd.data_valid,
		data:        down_cmd.data,
		left_valid:  down_pcm.left_valid,
		left:        down_pcm.left,
		right_valid: down_pcm.right_valid,
		right:       down_pcm.right
	};

endmodule

// File: tb/tb_ac97_subsys.sv
//////////////////////////////////////////////////
// Testbench for the AC'97 register and DMA subsystem.
// Reads tb/ac97_vectors.txt, so run it from the project root.
// Plays the AC-link transceiver and a one-cycle memory.
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_ac97_subsys import ac97_pkg::*; ();

	localparam logic [3:0] csr_page = 4'h2;
	localparam int frame_gap = 6;          // idle cycles before every frame strobe.
	localparam int cycles_per_vector = 200;

	logic        sys_clk = 1'b0;
	logic        sys_rst;
	csr_req_t    csr;
	logic [31:0] csr_do;
	irq_t        irq;
	logic        down_en;
	logic        down_next_frame;
	link_down_t  down;
	logic        up_en;
	logic        up_next_frame;
	link_up_t    up;
	mem_req_t    mem;
	logic [31:0] mem_rdata = 32'd0;

	logic [31:0] mem_model [logic [29:0]];
	logic        pre_we = 1'b0;
	logic [29:0] pre_addr = 30'd0;
	logic [31:0] pre_data = 32'd0;

	logic [3:0]  irq_bits;
	int          irq_count [0:3] = '{0, 0, 0, 0};
	int          irq_base [0:3];

	int          fd;
	int          code;
	int          vector_count = 0;
	logic [7:0]  op;
	logic [8*256-1:0] line;
	logic [31:0] fld [0:8];

	ac97_subsys #(
		.csr_addr(csr_page)
	) dut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr(csr),
		.csr_do(csr_do),
		.irq(irq),
		.down_en(down_en),
		.down_next_frame(down_next_frame),
		.down(down),
		.up_en(up_en),
		.up_next_frame(up_next_frame),
		.up(up),
		.mem(mem),
		.mem_rdata(mem_rdata)
	);

	always #10 sys_clk = ~sys_clk;

	//////////////////////////////////////////////////
	// memory model and interrupt monitor.
	//////////////////////////////////////////////////

	always @(posedge sys_clk) begin
		if (pre_we)
			mem_model[pre_addr] = pre_data;
		if (mem.wr)
			mem_model[mem.addr] = mem.wdata;
		if (mem.rd) // read data shows one cycle after the strobe.
			mem_rdata <= mem_model.exists(mem.addr) ? mem_model[mem.addr] : 32'd0;
	end

	assign irq_bits = irq;

	// pulses are counted at the falling edge, where they are stable.
	always @(negedge sys_clk) begin
		for (int i = 0; i < 4; i++) begin
			if (!sys_rst && irq_bits[i])
				irq_count[i] = irq_count[i] + 1;
		end
	end

	//////////////////////////////////////////////////
	// checker and bus tasks.
	//////////////////////////////////////////////////

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic read_fields(input int count);
		for (int i = 0; i < count; i++) begin
			code = $fscanf(fd, " %h", fld[i]);
			if (code != 1) begin
				$display("*** FAILED ***");
				$fatal(1, "a vector line has too few fields");
			end
		end
	endtask

	task automatic csr_write(input logic [13:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		csr <= '{addr: addr, we: 1'b1, data: data};
		@(posedge sys_clk);
		csr <= '0;
	endtask

	task automatic csr_read(input logic [13:0] addr, input logic [31:0] expected);
		@(posedge sys_clk);
		csr <= '{addr: addr, we: 1'b0, data: 32'd0};
		@(posedge sys_clk);
		csr <= '0;
		@(negedge sys_clk);
		check_value(csr_do, expected, "CSR read data");
	endtask

	task automatic preload(input logic [29:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		pre_we <= 1'b1;
		pre_addr <= addr;
		pre_data <= data;
		@(posedge sys_clk);
		pre_we <= 1'b0;
	endtask

	task automatic mem_check(input logic [29:0] addr, input logic [31:0] expected);
		@(negedge sys_clk);
		check_value(mem_model.exists(addr) ? mem_model[addr] : 32'd0, expected,
			"memory word");
	endtask

	// slots are compared only where the expected valid bit is set.
	task automatic down_frame();
		repeat (frame_gap + ($urandom % 4)) @(posedge sys_clk);
		down_next_frame <= 1'b1;
		@(posedge sys_clk);
		down_next_frame <= 1'b0;
		@(negedge sys_clk);
		check_value(32'(down.addr_valid), fld[0], "address slot valid");
		if (fld[0][0])
			check_value(32'(down.addr), fld[1], "address slot");
		check_value(32'(down.data_valid), fld[2], "data slot valid");
		if (fld[2][0])
			check_value(32'(down.data), fld[3], "data slot");
		check_value(32'(down.left_valid), fld[4], "left slot valid");
		check_value(32'(down.right_valid), fld[4], "right slot valid");
		if (fld[4][0]) begin
			check_value(32'(down.left), fld[5], "left slot");
			check_value(32'(down.right), fld[6], "right slot");
		end
	endtask

	task automatic up_frame();
		repeat (frame_gap + ($urandom % 4)) @(posedge sys_clk);
		up_next_frame <= 1'b1;
		up <= '{frame_valid: fld[0][0], addr_valid: fld[1][0], addr: fld[2][19:0],
			data_valid: fld[3][0], data: fld[4][19:0], left_valid: fld[5][0],
			left: fld[6][19:0], right_valid: fld[7][0], right: fld[8][19:0]};
		@(posedge sys_clk);
		up_next_frame <= 1'b0;
		up <= '0;
	endtask

	// mask bits are request sent, reply received, read done and write done.
	task automatic irq_expect(input logic [3:0] mask);
		logic [3:0] seen;
		repeat (4) @(posedge sys_clk);
		for (int i = 0; i < 4; i++) begin
			seen[i] = (irq_count[i] != irq_base[i]);
			irq_base[i] = irq_count[i];
		end
		check_value(32'(seen), 32'(mask), "interrupt flags");
	endtask

	//////////////////////////////////////////////////
	// vector interpreter.
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(42415));
		sys_rst = 1'b1;
		csr = '0;
		down_en = 1'b0;
		down_next_frame = 1'b0;
		up_en = 1'b0;
		up_next_frame = 1'b0;
		up = '0;
		irq_base = '{0, 0, 0, 0};

		fd = $fopen("tb/ac97_vectors.txt", "r");
		if (fd == 0) begin
			$display("*** FAILED ***");
			$fatal(1, "cannot open the vector file tb/ac97_vectors.txt");
		end
		while ($fgets(line, fd) != 0)
			vector_count = vector_count + 1;
		$fclose(fd);
		fd = $fopen("tb/ac97_vectors.txt", "r");

		repeat (5) @(posedge sys_clk);
		sys_rst <= 1'b0;
		down_en <= 1'b1; // the link runs for the whole test.
		up_en <= 1'b1;

		while ($fscanf(fd, " %c", op) == 1) begin
			case (op)
				"#": code = $fgets(line, fd);
				"W": begin
					read_fields(2);
					csr_write(fld[0][13:0], fld[1]);
				end
				"R": begin
					read_fields(2);
					csr_read(fld[0][13:0], fld[1]);
				end
				"P": begin
					read_fields(2);
					preload(fld[0][29:0], fld[1]);
				end
				"C": begin
					read_fields(2);
					mem_check(fld[0][29:0], fld[1]);
				end
				"N": begin
					read_fields(1);
					repeat (fld[0]) @(posedge sys_clk);
				end
				"D": begin
					read_fields(7);
					down_frame();
				end
				"U": begin
					read_fields(9);
					up_frame();
				end
				"I": begin
					read_fields(1);
					irq_expect(fld[0][3:0]);
				end
				default: begin
					$display("*** FAILED ***");
					$fatal(1, "unknown operation in the vector file");
				end
			endcase
		end
		$fclose(fd);
		$display("*** PASSED ***");
		$finish;
	end

	// the limit grows with the length of the vector file.
	initial begin
		wait (vector_count != 0);
		repeat (vector_count * cycles_per_vector) @(posedge sys_clk);
		$display("*** FAILED ***");
		$fatal(1, "the run took too long, the DUT seems stuck");
	end

endmodule

// File: tb/ac97_vectors.txt
# op, then hex fields: W addr data | R addr expect | P word data | C word expect | N cycles
# D av addr dv data pv left right | U fv av addr dv data lv left rv right | I irq mask
W 801 5a
W 802 1234
W 809 2000
W 80a fffc
R 801 5a
R 802 1234
R 809 2000
R 80a fffc
W 803 ffff
R 803 0
R 401 0
W 800 3
D 1 5a000 1 12340 0 0 0
I 8
R 800 2
W 800 1
D 1 da000 0 0 0 0 0
I 8
U 1 1 da000 1 abcd0 0 0 0 0
I 4
R 803 abcd
U 1 0 0 1 11110 0 0 0 0
I 0
R 803 abcd
P 400 11112222
P 401 33334444
W 805 1000
W 806 8
W 804 1
R 804 1
D 0 0 0 0 1 11110 22220
D 0 0 0 0 1 33330 44440
I 2
R 805 1008
R 806 0
D 0 0 0 0 0 0 0
W 80a 8
W 808 1
U 1 0 0 0 0 1 aaaa0 0 0
U 1 0 0 0 0 1 12340 1 56780
U 1 0 0 0 0 1 9abc0 1 def00
I 1
R 80a 0
R 809 2008
C 800 12345678
C 801 9abcdef0
C 802 0
P 500 01020304
P 501 05060708
W 805 1400
W 806 8
W 809 3000
W 80a 8
U 1 0 0 0 0 1 11110 1 22220
D 0 0 0 0 1 01020 03040
U 1 0 0 0 0 1 33330 1 44440
D 0 0 0 0 1 05060 07080
N 10
I 3
R 806 0
R 80a 0
C c00 11112222
C c01 33334444

// File: project.f
rtl/ac97_pkg.sv
rtl/ac97_ctlif.sv
rtl/ac97_dma_reader.sv
rtl/ac97_dma_writer.sv
rtl/ac97_mem_arbiter.sv
rtl/ac97_subsys.sv
tb/tb_ac97_subsys.sv

// File: Makefile
# Verilator build and run of the AC'97 subsystem testbench.

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary -j 0 --top-module tb_ac97_subsys -f project.f -o tb_ac97_subsys
	./obj_dir/tb_ac97_subsys

clean:
	rm -rf obj_dir
